// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

  // Address geometry of the microcode store
  localparam int OPCODE_W = 6;
  localparam int STEP_W = 5;
  localparam int WORD_W = 32;
  localparam int BYTE_W = 8;
  localparam int LANE_W = 2;
  localparam int LANES = WORD_W / BYTE_W;
  // Byte address is {opcode, step, lane}
  localparam int BOOT_ADDR_W = OPCODE_W + STEP_W + LANE_W;

  // Microword field layout
  localparam int CTRL_DATA_LO = 0;
  localparam int CTRL_DATA_W = 6;
  localparam int REG_SEL_LO = 6;
  localparam int REG_SEL_W = 2;
  localparam int PLANE_W = 3;
  localparam int OUT_PLANE_LO = 8;
  localparam int IN_PLANE_LO = 11;
  localparam int STEP_RESET_BIT = 14;
  localparam int MISC2_LO = 15;
  localparam int MISC2_W = 4;
  localparam int UNUSED_LO = 19;

  // Bits 31..19, must stay zero in every word
  localparam logic [WORD_W-1:0] UNUSED_MASK = ~((WORD_W'(1) << UNUSED_LO) - WORD_W'(1));

  // misc2 bit that picks ctrl_data as the opcode source
  localparam int MISC2_OPCODE_SRC = 0;
  // Illegal codes
  localparam logic [REG_SEL_W-1:0] REG_SEL_INVALID = 2'd3;
  // Left arithmetic shift, meaningless
  localparam logic [1:0] SHIFT_MODE_INVALID = 2'd3;

  // In plane, one load strobe per code
  typedef enum logic [PLANE_W-1:0] {
    IN_NONE   = 3'd0,
    IN_REG    = 3'd1,
    IN_TMP0   = 3'd2,
    IN_TMP1   = 3'd3,
    IN_MMU    = 3'd4,
    IN_OPWORD = 3'd5,
    IN_OPCODE = 3'd6,
    IN_RSVD   = 3'd7
  } in_plane_e;

  // Out plane, one bus driver per code
  typedef enum logic [PLANE_W-1:0] {
    OUT_NONE    = 3'd0,
    OUT_REG     = 3'd1,
    OUT_TMP0    = 3'd2,
    OUT_TMP1    = 3'd3,
    OUT_MMU     = 3'd4,
    OUT_MLU     = 3'd5,
    OUT_SHIFTER = 3'd6,
    OUT_TIMER   = 3'd7
  } out_plane_e;

endpackage

// File: rtl/ctrl_word_if.sv
`timescale 1ns/1ps

interface ctrl_word_if
  import ctrl_pkg::*;
#(
  parameter int OPCODE_W = ctrl_pkg::OPCODE_W,
  parameter int STEP_W = ctrl_pkg::STEP_W
) ();

  // Registered microword, split into its fields
  logic [CTRL_DATA_W-1:0] ctrl_data;
  logic [REG_SEL_W-1:0] reg_sel;
  in_plane_e in_plane;
  out_plane_e out_plane;
  logic step_reset;
  logic [MISC2_W-1:0] misc2;

  // Opcode may be loaded straight from ctrl_data
  if (OPCODE_W < 1 || OPCODE_W > CTRL_DATA_W) begin : g_opcode_w_check
    $error("ctrl_word_if: OPCODE_W %0d does not fit in ctrl_data", OPCODE_W);
  end

  // Step counter needs at least one bit
  if (STEP_W < 1) begin : g_step_w_check
    $error("ctrl_word_if: STEP_W %0d too small", STEP_W);
  end

  modport src (output ctrl_data, reg_sel, in_plane, out_plane, step_reset, misc2);
  modport seq (input ctrl_data, misc2, step_reset);
  modport dec (input ctrl_data, reg_sel, in_plane, out_plane, step_reset, misc2);

endinterface

// File: rtl/boot_loader.sv
`timescale 1ns/1ps

module boot_loader
  import ctrl_pkg::*;
(
  input  logic N_CLK,
  input  logic N_RST,
  input  logic boot_we,
  input  logic [BOOT_ADDR_W-1:0] boot_addr,
  input  logic [BYTE_W-1:0] boot_data,
  input  logic booted,
  output logic wr_en,
  output logic [BOOT_ADDR_W-LANE_W-1:0] wr_addr,
  output logic [LANE_W-1:0] wr_lane,
  output logic [BYTE_W-1:0] wr_data
);

  // Write strobe, one cycle behind boot_we
  // Dropped once the machine is booted
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= boot_we && !booted;
    end
  end

  // Byte address split into word address and lane
  // Only the upper bits select the microword
  always_ff @(posedge N_CLK) begin
    if (boot_we) begin
      wr_addr <= boot_addr[BOOT_ADDR_W-1:LANE_W];
      // Low bits pick the byte within the word
      wr_lane <= boot_addr[LANE_W-1:0];
      wr_data <= boot_data;
    end
  end

  // Bootstrap port is closed for good after boot
  a_no_write_after_boot: assert property (
    @(posedge N_CLK) disable iff (!N_RST)
    booted |-> !boot_we
  ) else $error("boot_loader: bootstrap write while booted");

endmodule

// File: rtl/microcode_store.sv
`timescale 1ns/1ps

module microcode_store
  import ctrl_pkg::*;
#(
  parameter int OPCODE_W = ctrl_pkg::OPCODE_W,
  parameter int STEP_W = ctrl_pkg::STEP_W
) (
  input logic N_CLK,
  input logic N_RST,
  input logic booted,
  input logic wr_en,
  input logic [OPCODE_W+STEP_W-1:0] wr_addr,
  input logic [LANE_W-1:0] wr_lane,
  input logic [BYTE_W-1:0] wr_data,
  input logic [OPCODE_W+STEP_W-1:0] rd_addr,
  ctrl_word_if.src word
);

  localparam int ADDR_W = OPCODE_W + STEP_W;
  localparam int DEPTH = 2 ** ADDR_W;

  // One word per {opcode, step}, four byte lanes each
  logic [LANES-1:0][BYTE_W-1:0] mem [DEPTH];
  logic [WORD_W-1:0] rd_word;
  logic [WORD_W-1:0] next_word;
  logic [BYTE_W-1:0] wr_unused_mask;

  // Byte-lane write from the bootstrap port
  always_ff @(posedge N_CLK) begin
    if (wr_en) begin
      mem[wr_addr][wr_lane] <= wr_data;
    end
  end

  assign rd_word = mem[rd_addr];
  // Zero word until booted, so every strobe stays idle
  assign next_word = booted ? rd_word : '0;

  // Microword register, split into fields
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      word.ctrl_data <= '0;
      word.reg_sel <= '0;
      word.out_plane <= OUT_NONE;
      word.in_plane <= IN_NONE;
      word.step_reset <= 1'b0;
      word.misc2 <= '0;
    end else begin
      word.ctrl_data <= next_word[CTRL_DATA_LO +: CTRL_DATA_W];
      word.reg_sel <= next_word[REG_SEL_LO +: REG_SEL_W];
      word.out_plane <= out_plane_e'(next_word[OUT_PLANE_LO +: PLANE_W]);
      word.in_plane <= in_plane_e'(next_word[IN_PLANE_LO +: PLANE_W]);
      word.step_reset <= next_word[STEP_RESET_BIT];
      word.misc2 <= next_word[MISC2_LO +: MISC2_W];
    end
  end

  // Unused bits falling in the lane being written
  assign wr_unused_mask = UNUSED_MASK[wr_lane*BYTE_W +: BYTE_W];

  a_unused_bits_zero: assert property (
    @(posedge N_CLK) disable iff (!N_RST)
    wr_en |-> ((wr_data & wr_unused_mask) == '0)
  ) else $error("microcode_store: nonzero unused bits in lane %0d", wr_lane);

endmodule

// File: rtl/micro_sequencer.sv
`timescale 1ns/1ps

module micro_sequencer
  import ctrl_pkg::*;
#(
  parameter int OPCODE_W = ctrl_pkg::OPCODE_W,
  parameter int STEP_W = ctrl_pkg::STEP_W
) (
  input  logic N_CLK,
  input  logic N_RST,
  input  logic booted,
  input  logic [OPCODE_W-1:0] opword_opcode,
  input  logic opcode_load,
  ctrl_word_if.seq word,
  output logic [OPCODE_W+STEP_W-1:0] rd_addr
);

  logic [OPCODE_W-1:0] opcode;
  logic [OPCODE_W-1:0] opcode_src;
  logic [STEP_W-1:0] step;

  // Opcode source mux
  // misc2 bit set takes the immediate from ctrl_data
  // clear takes the fetched opword
  always_comb begin
    if (word.misc2[MISC2_OPCODE_SRC]) begin
      opcode_src = word.ctrl_data[OPCODE_W-1:0];
    end else begin
      opcode_src = opword_opcode;
    end
  end

  // Opcode register
  // Held at zero until booted
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      opcode <= '0;
    end else if (!booted) begin
      opcode <= '0;
    end else if (opcode_load) begin
      opcode <= opcode_src;
    end
  end

  // Step counter
  // Back to step 0 on step_reset
  // Otherwise counts up and wraps at the top
  always_ff @(posedge N_CLK or negedge N_RST) begin
    if (!N_RST) begin
      step <= '0;
    end else if (!booted) begin
      step <= '0;
    end else if (word.step_reset) begin
      step <= '0;
    end else begin
      step <= step + STEP_W'(1);
    end
  end

  // Opcode in the upper address bits
  assign rd_addr = {opcode, step};

  // Opcode still zero one cycle after reset release
  a_opcode_clear_after_reset: assert property (
    @(posedge N_CLK)
    $rose(N_RST) |=> (opcode == '0)
  ) else $error("micro_sequencer: opcode %0h not clear after reset", opcode);

endmodule

// File: rtl/plane_decoder.sv
`timescale 1ns/1ps

module plane_decoder
  import ctrl_pkg::*;
(
  input  logic N_CLK,
  ctrl_word_if.dec word,
  // In plane, active-high load strobes
  output logic reg_in,
  output logic tmp0_in,
  output logic tmp1_in,
  output logic mmu_in,
  output logic opword_in,
  output logic opcode_load,
  // Out plane, active-low bus enables
  output logic reg_n_out,
  output logic tmp0_n_out,
  output logic tmp1_n_out,
  output logic mmu_n_out,
  output logic mlu_n_out,
  output logic shifter_n_out,
  output logic timer_n_out,
  // Data fields
  output logic [CTRL_DATA_W-1:0] ctrl_data,
  output logic [REG_SEL_W-1:0] reg_sel,
  output logic [MISC2_W-1:0] misc2
);

  logic load_drive_clash;

  // In plane, one-hot
  // IN_NONE and IN_RSVD raise nothing
  assign reg_in = (word.in_plane == IN_REG);
  assign tmp0_in = (word.in_plane == IN_TMP0);
  assign tmp1_in = (word.in_plane == IN_TMP1);
  assign mmu_in = (word.in_plane == IN_MMU);
  assign opword_in = (word.in_plane == IN_OPWORD);
  assign opcode_load = (word.in_plane == IN_OPCODE);

  // Out plane, at most one enable low
  assign reg_n_out = (word.out_plane != OUT_REG);
  assign tmp0_n_out = (word.out_plane != OUT_TMP0);
  assign tmp1_n_out = (word.out_plane != OUT_TMP1);
  assign mmu_n_out = (word.out_plane != OUT_MMU);
  assign mlu_n_out = (word.out_plane != OUT_MLU);
  assign shifter_n_out = (word.out_plane != OUT_SHIFTER);
  assign timer_n_out = (word.out_plane != OUT_TIMER);

  assign ctrl_data = word.ctrl_data;
  assign reg_sel = word.reg_sel;
  assign misc2 = word.misc2;

  // Same unit on both planes of one word
  assign load_drive_clash = (reg_in && !reg_n_out) || (tmp0_in && !tmp0_n_out) ||
                            (tmp1_in && !tmp1_n_out) || (mmu_in && !mmu_n_out);

  a_reg_sel_valid: assert property (
    @(posedge N_CLK) word.reg_sel != REG_SEL_INVALID
  ) else $error("plane_decoder: reg_sel %0d is not a register", word.reg_sel);

  // Shifter mode comes from misc2 while it drives the bus
  a_shift_mode_valid: assert property (
    @(posedge N_CLK) !shifter_n_out |-> (word.misc2[1:0] != SHIFT_MODE_INVALID)
  ) else $error("plane_decoder: left arithmetic shift requested");

  a_no_load_drive_clash: assert property (
    @(posedge N_CLK) !load_drive_clash
  ) else $error("plane_decoder: unit loaded and driven in one word");

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit
  import ctrl_pkg::*;
#(
  parameter int OPCODE_W = ctrl_pkg::OPCODE_W,
  parameter int STEP_W = ctrl_pkg::STEP_W
) (
  input  logic N_CLK,
  input  logic N_RST,
  input  logic [OPCODE_W-1:0] opword_opcode,
  // Bootstrap port
  input  logic boot_we,
  input  logic [BOOT_ADDR_W-1:0] boot_addr,
  input  logic [BYTE_W-1:0] boot_data,
  input  logic booted,
  // Load strobes
  output logic reg_in,
  output logic tmp0_in,
  output logic tmp1_in,
  output logic mmu_in,
  output logic opword_in,
  // Bus enables, active low
  output logic reg_n_out,
  output logic tmp0_n_out,
  output logic tmp1_n_out,
  output logic mmu_n_out,
  output logic mlu_n_out,
  output logic shifter_n_out,
  output logic timer_n_out,
  output logic [CTRL_DATA_W-1:0] ctrl_data,
  output logic [REG_SEL_W-1:0] reg_sel,
  output logic [MISC2_W-1:0] misc2
);

  logic wr_en;
  logic [OPCODE_W+STEP_W-1:0] wr_addr;
  logic [LANE_W-1:0] wr_lane;
  logic [BYTE_W-1:0] wr_data;
  logic [OPCODE_W+STEP_W-1:0] rd_addr;
  logic opcode_load;

  // Bootstrap byte address must cover exactly {opcode, step, lane}
  if (OPCODE_W + STEP_W + LANE_W != BOOT_ADDR_W) begin : g_boot_addr_check
    $error("control_unit: store geometry does not match BOOT_ADDR_W %0d", BOOT_ADDR_W);
  end

  ctrl_word_if #(.OPCODE_W(OPCODE_W), .STEP_W(STEP_W)) word_if ();

  boot_loader u_boot_loader (
    .N_CLK, .N_RST, .boot_we, .boot_addr, .boot_data, .booted,
    .wr_en, .wr_addr, .wr_lane, .wr_data
  );

  microcode_store #(.OPCODE_W(OPCODE_W), .STEP_W(STEP_W)) u_microcode_store (
    .N_CLK, .N_RST, .booted, .wr_en, .wr_addr, .wr_lane, .wr_data, .rd_addr,
    .word (word_if.src)
  );

  // Opcode load strobe comes back from the decoder
  micro_sequencer #(.OPCODE_W(OPCODE_W), .STEP_W(STEP_W)) u_micro_sequencer (
    .N_CLK, .N_RST, .booted, .opword_opcode, .opcode_load,
    .word (word_if.seq),
    .rd_addr
  );

  plane_decoder u_plane_decoder (
    .N_CLK,
    .word (word_if.dec),
    .reg_in, .tmp0_in, .tmp1_in, .mmu_in, .opword_in, .opcode_load,
    .reg_n_out, .tmp0_n_out, .tmp1_n_out, .mmu_n_out,
    .mlu_n_out, .shifter_n_out, .timer_n_out,
    .ctrl_data, .reg_sel, .misc2
  );

endmodule

// File: tb/tb_microcode_table.svh
`ifndef TB_MICROCODE_TABLE_SVH
`define TB_MICROCODE_TABLE_SVH

// One row per cycle after boot
// exp_in is {reg, tmp0, tmp1, mmu, opword}
// exp_n_out is {reg, tmp0, tmp1, mmu, mlu, shifter, timer}
typedef struct packed {
  logic use_op;
  logic [5:0] op;
  logic [4:0] exp_in;
  logic [6:0] exp_n_out;
} row_t;

localparam int ROWS = 10;

// Test microprogram, indexed by {opcode, step}
logic [31:0] prog [2048];
logic [10:0] prog_addr [$];
row_t table_rows [ROWS];

// Field packing of one microword
function automatic logic [31:0] microword(input logic [2:0] in_code, input logic [2:0] out_code,
    input logic sr, input logic [3:0] m2, input logic [1:0] rs, input logic [5:0] data);
  return {13'd0, m2, sr, in_code, out_code, rs, data};
endfunction

// Opcode 3 words, no step reset anywhere
function automatic logic [31:0] fill_word(input logic [10:0] a);
  logic [1:0] rs;
  rs = (a[1:0] == 2'd3) ? 2'd2 : a[1:0];
  return microword(3'd0, a[2:0], 1'b0, {a[3:2], 2'b00}, rs, a[5:0] ^ a[10:5]);
endfunction

task automatic put_word(input logic [5:0] op, input logic [4:0] step, input logic [31:0] w);
  prog[{op, step}] = w;
  prog_addr.push_back({op, step});
endtask

task automatic build_program();
  // Opcode 0 walks every in and out code
  put_word(6'd0, 5'd0, microword(3'd1, 3'd2, 1'b0, 4'b0000, 2'd1, 6'h05));
  put_word(6'd0, 5'd1, microword(3'd2, 3'd3, 1'b0, 4'b0000, 2'd2, 6'h0a));
  put_word(6'd0, 5'd2, microword(3'd3, 3'd4, 1'b0, 4'b0000, 2'd0, 6'h11));
  put_word(6'd0, 5'd3, microword(3'd4, 3'd5, 1'b0, 4'b0000, 2'd1, 6'h16));
  put_word(6'd0, 5'd4, microword(3'd5, 3'd6, 1'b0, 4'b0010, 2'd2, 6'h2b));
  // Opcode from the opword, then back to step 0
  put_word(6'd0, 5'd5, microword(3'd6, 3'd7, 1'b1, 4'b0000, 2'd0, 6'h30));
  // Delay slot, reserved in code
  put_word(6'd0, 5'd6, microword(3'd7, 3'd1, 1'b0, 4'b1000, 2'd1, 6'h3f));
  put_word(6'd2, 5'd0, microword(3'd0, 3'd2, 1'b0, 4'b0000, 2'd2, 6'h21));
  // Immediate opcode 3 from ctrl_data
  put_word(6'd2, 5'd1, microword(3'd6, 3'd0, 1'b1, 4'b0001, 2'd0, 6'h03));
  put_word(6'd2, 5'd2, microword(3'd0, 3'd3, 1'b0, 4'b0100, 2'd1, 6'h12));
  for (int s = 0; s < 32; s++) begin
    put_word(6'd3, s[4:0], fill_word({6'd3, s[4:0]}));
  end
  table_rows[0] = {1'b0, 6'd0, 5'b10000, 7'b1011111};
  table_rows[1] = {1'b0, 6'd0, 5'b01000, 7'b1101111};
  table_rows[2] = {1'b0, 6'd0, 5'b00100, 7'b1110111};
  table_rows[3] = {1'b0, 6'd0, 5'b00010, 7'b1111011};
  table_rows[4] = {1'b0, 6'd0, 5'b00001, 7'b1111101};
  table_rows[5] = {1'b1, 6'd2, 5'b00000, 7'b1111110};
  table_rows[6] = {1'b0, 6'd0, 5'b00000, 7'b0111111};
  table_rows[7] = {1'b0, 6'd0, 5'b00000, 7'b1011111};
  // Decoy opword, ctrl_data must win
  table_rows[8] = {1'b1, 6'd2, 5'b00000, 7'b1111111};
  table_rows[9] = {1'b0, 6'd0, 5'b00000, 7'b1101111};
endtask

`endif

// File: tb/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit
  import ctrl_pkg::*;
();

  logic N_CLK;
  logic N_RST;
  logic [OPCODE_W-1:0] opword_opcode;
  logic boot_we;
  logic [BOOT_ADDR_W-1:0] boot_addr;
  logic [BYTE_W-1:0] boot_data;
  logic booted;
  logic reg_in, tmp0_in, tmp1_in, mmu_in, opword_in;
  logic reg_n_out, tmp0_n_out, tmp1_n_out, mmu_n_out, mlu_n_out, shifter_n_out, timer_n_out;
  logic [CTRL_DATA_W-1:0] ctrl_data;
  logic [REG_SEL_W-1:0] reg_sel;
  logic [MISC2_W-1:0] misc2;
  // Reference model state
  logic [5:0] m_op;
  logic [4:0] m_step;
  logic [31:0] m_word;
  int error_count;
  int unsigned seed_val;

  `include "tb_microcode_table.svh"

  control_unit #(.OPCODE_W(OPCODE_W), .STEP_W(STEP_W)) dut (
    .N_CLK, .N_RST, .opword_opcode, .boot_we, .boot_addr, .boot_data, .booted,
    .reg_in, .tmp0_in, .tmp1_in, .mmu_in, .opword_in,
    .reg_n_out, .tmp0_n_out, .tmp1_n_out, .mmu_n_out, .mlu_n_out, .shifter_n_out,
    .timer_n_out, .ctrl_data, .reg_sel, .misc2
  );

  initial begin
    N_CLK = 1'b0;
    forever #2 N_CLK = ~N_CLK;
  end

  function automatic logic [4:0] expect_in(input logic [31:0] w);
    logic [2:0] c;
    c = w[13:11];
    return {c == 3'd1, c == 3'd2, c == 3'd3, c == 3'd4, c == 3'd5};
  endfunction

  function automatic logic [6:0] expect_n_out(input logic [31:0] w);
    logic [2:0] c;
    c = w[10:8];
    return ~{c == 3'd1, c == 3'd2, c == 3'd3, c == 3'd4, c == 3'd5, c == 3'd6, c == 3'd7};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Rising edge, model sees the inputs the DUT sampled
  task automatic clock_edge();
    logic [31:0] nw;
    logic [4:0] ns;
    logic [5:0] nop;
    @(posedge N_CLK);
    if (!N_RST || !booted) begin
      m_op = '0;
      m_step = '0;
      m_word = '0;
    end else begin
      nw = prog[{m_op, m_step}];
      ns = m_word[14] ? 5'd0 : m_step + 5'd1;
      nop = m_op;
      // Opcode load, source picked by misc2 bit 0
      if (m_word[13:11] == 3'd6) begin
        nop = m_word[15] ? m_word[5:0] : opword_opcode;
      end
      m_word = nw;
      m_step = ns;
      m_op = nop;
    end
  endtask

  // Outputs are stable by the falling edge
  task automatic check_at_fall();
    @(negedge N_CLK);
    check_value("in strobes", 32'({reg_in, tmp0_in, tmp1_in, mmu_in, opword_in}),
                32'(expect_in(m_word)));
    check_value("bus enables", 32'({reg_n_out, tmp0_n_out, tmp1_n_out, mmu_n_out,
                mlu_n_out, shifter_n_out, timer_n_out}), 32'(expect_n_out(m_word)));
    check_value("ctrl_data", 32'(ctrl_data), 32'(m_word[5:0]));
    check_value("reg_sel", 32'(reg_sel), 32'(m_word[7:6]));
    check_value("misc2", 32'(misc2), 32'(m_word[18:15]));
  endtask

  task automatic drive_filler_opword();
    logic [31:0] rnd;
    rnd = $urandom;
    opword_opcode <= rnd[5:0];
  endtask

  initial begin
    logic [10:0] a;
    logic [31:0] top_word;
    logic [31:0] base_word;
    logic seen_top;
    logic done;
    int timeout;
    error_count = 0;
    seed_val = $urandom(32'h62e70ed9);
    N_RST = 1'b0;
    booted = 1'b0;
    boot_we = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    opword_opcode = '0;
    m_op = '0;
    m_step = '0;
    m_word = '0;
    build_program();
    // Reset for 4 cycles, outputs idle
    for (int i = 0; i < 4; i++) begin
      clock_edge();
      if (i == 3) N_RST <= 1'b1;
      check_at_fall();
    end
    // Byte-wise boot, still idle
    foreach (prog_addr[i]) begin
      for (int lane = 0; lane < 4; lane++) begin
        clock_edge();
        a = prog_addr[i];
        boot_we <= 1'b1;
        boot_addr <= {a, lane[1:0]};
        boot_data <= prog[a][lane*8 +: 8];
        check_at_fall();
      end
    end
    // Last bytes land two edges after their strobe
    for (int i = 0; i < 3; i++) begin
      clock_edge();
      boot_we <= 1'b0;
      check_at_fall();
    end
    clock_edge();
    booted <= 1'b1;
    check_at_fall();
    // Table rows, model cross-checked against each row
    for (int r = 0; r < ROWS; r++) begin
      clock_edge();
      if (table_rows[r].use_op) opword_opcode <= table_rows[r].op;
      else drive_filler_opword();
      check_at_fall();
      check_value("table in strobes", 32'(expect_in(m_word)), 32'(table_rows[r].exp_in));
      check_value("table bus enables", 32'(expect_n_out(m_word)),
                  32'(table_rows[r].exp_n_out));
    end
    // Opcode 3 runs off step 31 back to step 0
    top_word = fill_word({6'd3, 5'd31});
    base_word = fill_word({6'd3, 5'd0});
    seen_top = 1'b0;
    done = 1'b0;
    timeout = 0;
    while (!done) begin
      clock_edge();
      drive_filler_opword();
      check_at_fall();
      if (seen_top && ctrl_data == base_word[5:0]) done = 1'b1;
      if (ctrl_data == top_word[5:0]) seen_top = 1'b1;
      timeout++;
      if (!done && timeout > 48) begin
        $display("Timed out waiting for the step counter to wrap from 31 to 0");
        $display("Regression failed");
        $fatal(1, "wrap timeout");
      end
    end
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+tb
rtl/ctrl_pkg.sv
rtl/ctrl_word_if.sv
rtl/boot_loader.sv
rtl/microcode_store.sv
rtl/micro_sequencer.sv
rtl/plane_decoder.sv
rtl/control_unit.sv
tb/tb_control_unit.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - rtl/ctrl_pkg.sv
  - rtl/ctrl_word_if.sv
  - rtl/boot_loader.sv
  - rtl/microcode_store.sv
  - rtl/micro_sequencer.sv
  - rtl/plane_decoder.sv
  - rtl/control_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_control_unit.sv
